// File: src/axil_pkg.sv
`default_nettype none

package axil_pkg;

	// --------------------
	// Protection codes
	// --------------------

	// Write side: unprivileged, secure, data access
	parameter logic [2:0] AXI_PROT_WR = 3'b000;
	// Read side: privileged, secure, data access
	parameter logic [2:0] AXI_PROT_RD = 3'b001;

	// --------------------
	// Response decoding
	// --------------------

	// Bit 1 of BRESP/RRESP is set for SLVERR and DECERR
	parameter int AXI_RESP_ERR_BIT = 1;

	// --------------------
	// Default widths
	// --------------------

	// AXI address and data buses
	parameter int DEF_AXI_ADDR_W = 32;
	parameter int DEF_AXI_DATA_W = 32;
	// CPU request port, address and data alike
	parameter int DEF_CPU_W = 16;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		WRITE = 2'b01,
		READ  = 2'b10
	} seq_state_t;

endpackage

`default_nettype wire

// File: src/txn_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module txn_sequencer
	import axil_pkg::*;
#(
	parameter int AXI_ADDR_W = DEF_AXI_ADDR_W,
	parameter int AXI_DATA_W = DEF_AXI_DATA_W,
	parameter int CPU_W = DEF_CPU_W
)
(
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,

	// CPU request port
	input wire start_i,
	input wire rw_i,
	input wire [CPU_W-1:0] cpu_rw_addr_i,
	input wire [CPU_W-1:0] cpu_w_data_i,

	// Completion from the write channel
	input wire wr_done_i,
	input wire wr_err_i,

	// Completion from the read channel
	input wire rd_done_i,
	input wire rd_err_i,
	input wire [CPU_W-1:0] rd_data_i,

	// Command to the channels
	output logic wr_launch_o,
	output logic rd_launch_o,
	output logic [AXI_ADDR_W-1:0] cmd_addr_o,
	output logic [AXI_DATA_W-1:0] cmd_wdata_o,

	// CPU result port
	output logic busy_o,
	output logic [CPU_W-1:0] cpu_r_addr_o,
	output logic [CPU_W-1:0] cpu_r_data_o,
	output logic err_o
);

	seq_state_t state_q;

	// Previous start level, for edge detection
	logic start_q;
	logic start_edge;
	// Edge only counts while idle
	logic accept;

	// One-cycle launch pulses
	logic wr_launch_q;
	logic rd_launch_q;

	// Latched command, zero-extended to bus width
	logic [AXI_ADDR_W-1:0] cmd_addr_q;
	logic [AXI_DATA_W-1:0] cmd_wdata_q;

	// Result registers seen by the CPU
	logic err_q;
	logic [CPU_W-1:0] cpu_r_addr_q;
	logic [CPU_W-1:0] cpu_r_data_q;

	assign start_edge = start_i & ~start_q;
	assign accept = start_edge && (state_q == IDLE);

	// --------------------
	// Start edge register
	// --------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= start_i;
		end
	end

	// --------------------
	// Command latch
	// --------------------

	// Requester holds inputs stable while start is high
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (accept)
		begin
			cmd_addr_q <= {{(AXI_ADDR_W-CPU_W){1'b0}}, cpu_rw_addr_i};
			cmd_wdata_q <= {{(AXI_DATA_W-CPU_W){1'b0}}, cpu_w_data_i};
		end
	end

	// --------------------
	// Transaction FSM
	// --------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			state_q <= IDLE;
			wr_launch_q <= 1'b0;
			rd_launch_q <= 1'b0;
		end
		else
		begin
			// Launch is a single-cycle pulse
			wr_launch_q <= 1'b0;
			rd_launch_q <= 1'b0;
			case (state_q)
				IDLE:
				begin
					if (accept)
					begin
						state_q <= rw_i ? WRITE : READ;
						wr_launch_q <= rw_i;
						rd_launch_q <= ~rw_i;
					end
				end
				WRITE:
				begin
					// Back to idle once B handshake completes
					if (wr_done_i)
					begin
						state_q <= IDLE;
					end
				end
				READ:
				begin
					// Back to idle once R handshake completes
					if (rd_done_i)
					begin
						state_q <= IDLE;
					end
				end
				default:
				begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// --------------------
	// CPU result registers
	// --------------------

	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			err_q <= 1'b0;
			cpu_r_addr_q <= '0;
			cpu_r_data_q <= '0;
		end
		else if ((state_q == WRITE) && wr_done_i)
		begin
			err_q <= wr_err_i;
		end
		else if ((state_q == READ) && rd_done_i)
		begin
			err_q <= rd_err_i;
			cpu_r_addr_q <= cmd_addr_q[CPU_W-1:0];
			cpu_r_data_q <= rd_data_i;
		end
	end

	// Busy covers launch through the response handshake
	assign busy_o = (state_q != IDLE);

	assign wr_launch_o = wr_launch_q;
	assign rd_launch_o = rd_launch_q;
	assign cmd_addr_o = cmd_addr_q;
	assign cmd_wdata_o = cmd_wdata_q;
	assign err_o = err_q;
	assign cpu_r_addr_o = cpu_r_addr_q;
	assign cpu_r_data_o = cpu_r_data_q;

endmodule

`default_nettype wire

// File: src/axil_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_write_channel
	import axil_pkg::*;
#(
	parameter int AXI_ADDR_W = DEF_AXI_ADDR_W,
	parameter int AXI_DATA_W = DEF_AXI_DATA_W,
	parameter int CPU_W = DEF_CPU_W
)
(
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,

	// Command from the sequencer
	input wire launch_i,
	input wire [AXI_ADDR_W-1:0] addr_i,
	input wire [AXI_DATA_W-1:0] data_i,

	// Write address channel
	output logic [AXI_ADDR_W-1:0] M_AXI_AWADDR,
	output logic [2:0] M_AXI_AWPROT,
	output logic M_AXI_AWVALID,
	input wire M_AXI_AWREADY,

	// Write data channel
	output logic [AXI_DATA_W-1:0] M_AXI_WDATA,
	output logic [AXI_DATA_W/8-1:0] M_AXI_WSTRB,
	output logic M_AXI_WVALID,
	input wire M_AXI_WREADY,

	// Write response channel
	input wire [1:0] M_AXI_BRESP,
	input wire M_AXI_BVALID,
	output logic M_AXI_BREADY,

	// Completion to the sequencer
	output logic done_o,
	output logic err_o
);

	localparam int STRB_W = AXI_DATA_W/8;
	// Low lanes covered by the CPU data width
	localparam logic [STRB_W-1:0] WSTRB_VAL = {STRB_W{1'b1}} >> (STRB_W - CPU_W/8);

	logic awvalid_q;
	logic wvalid_q;
	logic bready_q;

	// --------------------
	// AW channel
	// --------------------

	// Held until AWREADY, independent of W
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			awvalid_q <= 1'b0;
		end
		else if (launch_i)
		begin
			awvalid_q <= 1'b1;
		end
		else if (M_AXI_AWREADY)
		begin
			awvalid_q <= 1'b0;
		end
	end

	// --------------------
	// W channel
	// --------------------

	// Rises with AWVALID, falls on its own READY
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			wvalid_q <= 1'b0;
		end
		else if (launch_i)
		begin
			wvalid_q <= 1'b1;
		end
		else if (M_AXI_WREADY)
		begin
			wvalid_q <= 1'b0;
		end
	end

	// --------------------
	// B channel
	// --------------------

	// One-cycle BREADY after BVALID is first seen
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			bready_q <= 1'b0;
		end
		else
		begin
			bready_q <= M_AXI_BVALID & ~bready_q;
		end
	end

	// Address and data come from the latched command
	assign M_AXI_AWADDR = addr_i;
	assign M_AXI_AWPROT = AXI_PROT_WR;
	assign M_AXI_AWVALID = awvalid_q;
	assign M_AXI_WDATA = data_i;
	assign M_AXI_WSTRB = WSTRB_VAL;
	assign M_AXI_WVALID = wvalid_q;
	assign M_AXI_BREADY = bready_q;

	// Handshake completes in the BREADY cycle
	assign done_o = bready_q & M_AXI_BVALID;
	assign err_o = done_o & M_AXI_BRESP[AXI_RESP_ERR_BIT];

endmodule

`default_nettype wire

// File: src/axil_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axil_read_channel
	import axil_pkg::*;
#(
	parameter int AXI_ADDR_W = DEF_AXI_ADDR_W,
	parameter int AXI_DATA_W = DEF_AXI_DATA_W,
	parameter int CPU_W = DEF_CPU_W
)
(
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,

	// Command from the sequencer
	input wire launch_i,
	input wire [AXI_ADDR_W-1:0] addr_i,

	// Read address channel
	output logic [AXI_ADDR_W-1:0] M_AXI_ARADDR,
	output logic [2:0] M_AXI_ARPROT,
	output logic M_AXI_ARVALID,
	input wire M_AXI_ARREADY,

	// Read data channel
	input wire [AXI_DATA_W-1:0] M_AXI_RDATA,
	input wire [1:0] M_AXI_RRESP,
	input wire M_AXI_RVALID,
	output logic M_AXI_RREADY,

	// Completion to the sequencer
	output logic done_o,
	output logic err_o,
	output logic [CPU_W-1:0] rdata_o
);

	logic arvalid_q;
	logic rready_q;

	// --------------------
	// AR channel
	// --------------------

	// Held until ARREADY
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			arvalid_q <= 1'b0;
		end
		else if (launch_i)
		begin
			arvalid_q <= 1'b1;
		end
		else if (M_AXI_ARREADY)
		begin
			arvalid_q <= 1'b0;
		end
	end

	// --------------------
	// R channel
	// --------------------

	// One-cycle RREADY after RVALID is first seen
	always_ff @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			rready_q <= 1'b0;
		end
		else
		begin
			rready_q <= M_AXI_RVALID & ~rready_q;
		end
	end

	assign M_AXI_ARADDR = addr_i;
	assign M_AXI_ARPROT = AXI_PROT_RD;
	assign M_AXI_ARVALID = arvalid_q;
	assign M_AXI_RREADY = rready_q;

	// Data is taken by the sequencer on done
	assign done_o = rready_q & M_AXI_RVALID;
	assign err_o = done_o & M_AXI_RRESP[AXI_RESP_ERR_BIT];
	// Only the CPU-width low part is returned
	assign rdata_o = M_AXI_RDATA[CPU_W-1:0];

endmodule

`default_nettype wire

// File: src/axil_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_master_top
	import axil_pkg::*;
#(
	parameter int AXI_ADDR_W = DEF_AXI_ADDR_W,
	parameter int AXI_DATA_W = DEF_AXI_DATA_W,
	parameter int CPU_W = DEF_CPU_W
)
(
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,

	// --------------------
	// CPU side
	// --------------------
	input wire start_i,
	// 1 selects a write
	input wire rw_i,
	input wire [CPU_W-1:0] cpu_rw_addr_i,
	input wire [CPU_W-1:0] cpu_w_data_i,
	output logic busy_o,
	output logic [CPU_W-1:0] cpu_r_addr_o,
	output logic [CPU_W-1:0] cpu_r_data_o,
	output logic err_o,

	// --------------------
	// AXI4-Lite side
	// --------------------
	output logic [AXI_ADDR_W-1:0] M_AXI_AWADDR,
	output logic [2:0] M_AXI_AWPROT,
	output logic M_AXI_AWVALID,
	input wire M_AXI_AWREADY,
	output logic [AXI_DATA_W-1:0] M_AXI_WDATA,
	output logic [AXI_DATA_W/8-1:0] M_AXI_WSTRB,
	output logic M_AXI_WVALID,
	input wire M_AXI_WREADY,
	input wire [1:0] M_AXI_BRESP,
	input wire M_AXI_BVALID,
	output logic M_AXI_BREADY,
	output logic [AXI_ADDR_W-1:0] M_AXI_ARADDR,
	output logic [2:0] M_AXI_ARPROT,
	output logic M_AXI_ARVALID,
	input wire M_AXI_ARREADY,
	input wire [AXI_DATA_W-1:0] M_AXI_RDATA,
	input wire [1:0] M_AXI_RRESP,
	input wire M_AXI_RVALID,
	output logic M_AXI_RREADY
);

	// Sequencer to channels
	logic wr_launch;
	logic rd_launch;
	logic [AXI_ADDR_W-1:0] cmd_addr;
	logic [AXI_DATA_W-1:0] cmd_wdata;

	// Channels to sequencer
	logic wr_done;
	logic wr_err;
	logic rd_done;
	logic rd_err;
	logic [CPU_W-1:0] rd_data;

	// Edge detect, command latch and result registers
	txn_sequencer #(
		.AXI_ADDR_W (AXI_ADDR_W),
		.AXI_DATA_W (AXI_DATA_W),
		.CPU_W (CPU_W)
	) u_seq (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.start_i (start_i),
		.rw_i (rw_i),
		.cpu_rw_addr_i (cpu_rw_addr_i),
		.cpu_w_data_i (cpu_w_data_i),
		.wr_done_i (wr_done),
		.wr_err_i (wr_err),
		.rd_done_i (rd_done),
		.rd_err_i (rd_err),
		.rd_data_i (rd_data),
		.wr_launch_o (wr_launch),
		.rd_launch_o (rd_launch),
		.cmd_addr_o (cmd_addr),
		.cmd_wdata_o (cmd_wdata),
		.busy_o (busy_o),
		.cpu_r_addr_o (cpu_r_addr_o),
		.cpu_r_data_o (cpu_r_data_o),
		.err_o (err_o)
	);

	// AW, W and B handshakes
	axil_write_channel #(
		.AXI_ADDR_W (AXI_ADDR_W),
		.AXI_DATA_W (AXI_DATA_W),
		.CPU_W (CPU_W)
	) u_wr (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.launch_i (wr_launch),
		.addr_i (cmd_addr),
		.data_i (cmd_wdata),
		.M_AXI_AWADDR (M_AXI_AWADDR),
		.M_AXI_AWPROT (M_AXI_AWPROT),
		.M_AXI_AWVALID (M_AXI_AWVALID),
		.M_AXI_AWREADY (M_AXI_AWREADY),
		.M_AXI_WDATA (M_AXI_WDATA),
		.M_AXI_WSTRB (M_AXI_WSTRB),
		.M_AXI_WVALID (M_AXI_WVALID),
		.M_AXI_WREADY (M_AXI_WREADY),
		.M_AXI_BRESP (M_AXI_BRESP),
		.M_AXI_BVALID (M_AXI_BVALID),
		.M_AXI_BREADY (M_AXI_BREADY),
		.done_o (wr_done),
		.err_o (wr_err)
	);

	// AR and R handshakes
	axil_read_channel #(
		.AXI_ADDR_W (AXI_ADDR_W),
		.AXI_DATA_W (AXI_DATA_W),
		.CPU_W (CPU_W)
	) u_rd (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.launch_i (rd_launch),
		.addr_i (cmd_addr),
		.M_AXI_ARADDR (M_AXI_ARADDR),
		.M_AXI_ARPROT (M_AXI_ARPROT),
		.M_AXI_ARVALID (M_AXI_ARVALID),
		.M_AXI_ARREADY (M_AXI_ARREADY),
		.M_AXI_RDATA (M_AXI_RDATA),
		.M_AXI_RRESP (M_AXI_RRESP),
		.M_AXI_RVALID (M_AXI_RVALID),
		.M_AXI_RREADY (M_AXI_RREADY),
		.done_o (rd_done),
		.err_o (rd_err),
		.rdata_o (rd_data)
	);

endmodule

`default_nettype wire

// File: dv/clk_rst_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RST_CYCLES = 4
)
(
	output logic clk_o,
	output logic rst_n_o
);

	// Free-running clock
	initial
	begin
		clk_o = 1'b0;
		forever #(PERIOD_NS/2) clk_o = ~clk_o;
	end

	// Low for RST_CYCLES rising edges, released on a falling edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/axil_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave_model (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	input wire [31:0] awaddr_i,
	input wire awvalid_i,
	output logic awready_o,
	input wire [31:0] wdata_i,
	input wire [3:0] wstrb_i,
	input wire wvalid_i,
	output logic wready_o,
	output logic [1:0] bresp_o,
	output logic bvalid_o,
	input wire bready_i,
	input wire [31:0] araddr_i,
	input wire arvalid_i,
	output logic arready_o,
	output logic [31:0] rdata_o,
	output logic [1:0] rresp_o,
	output logic rvalid_o,
	input wire rready_i
);

	// Word memory indexed by the full address
	logic [31:0] mem [logic [31:0]];

	// Bus outputs, quiet from time zero
	logic awready_q = 1'b0;
	logic wready_q = 1'b0;
	logic bvalid_q = 1'b0;
	logic [1:0] bresp_q = 2'b00;
	logic arready_q = 1'b0;
	logic rvalid_q = 1'b0;
	logic [1:0] rresp_q = 2'b00;
	logic [31:0] rdata_q = 32'h0;

	// Captured address and data phases
	logic aw_got;
	logic w_got;
	logic ar_got;
	logic [31:0] aw_addr;
	logic [31:0] w_data;
	logic [3:0] w_strb;
	logic [31:0] ar_addr;

	// Remaining wait cycles per channel
	int aw_dly;
	int w_dly;
	int b_dly;
	int ar_dly;
	int r_dly;

	function automatic int rand_delay();
		return int'($urandom % 8);
	endfunction

	// Byte-lane merge into the stored word
	task automatic store_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] word;
		word = mem.exists(a) ? mem[a] : 32'h0;
		for (int i = 0; i < 4; i++)
		begin
			if (s[i])
			begin
				word[8*i +: 8] = d[8*i +: 8];
			end
		end
		mem[a] = word;
	endtask

	// --------------------
	// Write side
	// --------------------

	always @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			awready_q <= 1'b0;
			wready_q <= 1'b0;
			bvalid_q <= 1'b0;
			bresp_q <= 2'b00;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			aw_dly <= rand_delay();
			w_dly <= rand_delay();
			b_dly <= rand_delay();
		end
		else
		begin
			// AWREADY for one cycle after a random wait
			if (awready_q)
			begin
				awready_q <= 1'b0;
				aw_got <= 1'b1;
				aw_addr <= awaddr_i;
				aw_dly <= rand_delay();
			end
			else if (awvalid_i && !aw_got)
			begin
				if (aw_dly == 0)
					awready_q <= 1'b1;
				else
					aw_dly <= aw_dly - 1;
			end
			// Same scheme on W, independent delay
			if (wready_q)
			begin
				wready_q <= 1'b0;
				w_got <= 1'b1;
				w_data <= wdata_i;
				w_strb <= wstrb_i;
				w_dly <= rand_delay();
			end
			else if (wvalid_i && !w_got)
			begin
				if (w_dly == 0)
					wready_q <= 1'b1;
				else
					w_dly <= w_dly - 1;
			end
			// BVALID held until BREADY
			if (bvalid_q)
			begin
				if (bready_i)
					bvalid_q <= 1'b0;
			end
			else if (aw_got && w_got)
			begin
				if (b_dly == 0)
				begin
					// Bit 15 addresses answer SLVERR and are not stored
					bvalid_q <= 1'b1;
					bresp_q <= aw_addr[15] ? 2'b10 : 2'b00;
					if (!aw_addr[15])
						store_write(aw_addr, w_data, w_strb);
					aw_got <= 1'b0;
					w_got <= 1'b0;
					b_dly <= rand_delay();
				end
				else
					b_dly <= b_dly - 1;
			end
		end
	end

	// --------------------
	// Read side
	// --------------------

	always @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			rresp_q <= 2'b00;
			ar_got <= 1'b0;
			ar_dly <= rand_delay();
			r_dly <= rand_delay();
		end
		else
		begin
			if (arready_q)
			begin
				arready_q <= 1'b0;
				ar_got <= 1'b1;
				ar_addr <= araddr_i;
				ar_dly <= rand_delay();
			end
			else if (arvalid_i && !ar_got)
			begin
				if (ar_dly == 0)
					arready_q <= 1'b1;
				else
					ar_dly <= ar_dly - 1;
			end
			// RVALID held until RREADY
			if (rvalid_q)
			begin
				if (rready_i)
					rvalid_q <= 1'b0;
			end
			else if (ar_got)
			begin
				if (r_dly == 0)
				begin
					rvalid_q <= 1'b1;
					rresp_q <= ar_addr[15] ? 2'b10 : 2'b00;
					if (ar_addr[15] || !mem.exists(ar_addr))
						rdata_q <= 32'h0;
					else
						rdata_q <= mem[ar_addr];
					ar_got <= 1'b0;
					r_dly <= rand_delay();
				end
				else
					r_dly <= r_dly - 1;
			end
		end
	end

	assign awready_o = awready_q;
	assign wready_o = wready_q;
	assign bvalid_o = bvalid_q;
	assign bresp_o = bresp_q;
	assign arready_o = arready_q;
	assign rvalid_o = rvalid_q;
	assign rresp_o = rresp_q;
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: dv/axil_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axil_checker (
	input wire M_AXI_ACLK,
	input wire M_AXI_ARESETN,
	// CPU side
	input wire start_i,
	input wire rw_i,
	input wire [15:0] cpu_addr_i,
	input wire [15:0] cpu_wdata_i,
	input wire busy_i,
	input wire [15:0] cpu_r_addr_i,
	input wire [15:0] cpu_r_data_i,
	input wire err_i,
	// AXI side
	input wire [31:0] awaddr_i,
	input wire [2:0] awprot_i,
	input wire awvalid_i,
	input wire awready_i,
	input wire [31:0] wdata_i,
	input wire [3:0] wstrb_i,
	input wire wvalid_i,
	input wire wready_i,
	input wire bready_i,
	input wire [31:0] araddr_i,
	input wire [2:0] arprot_i,
	input wire arvalid_i,
	input wire arready_i,
	input wire rready_i,
	// Totals for the closing report
	output int err_cnt_o,
	output int acc_cnt_o,
	output int bus_cnt_o
);

	// Expected bus constants
	localparam logic [2:0] PROT_WR_EXP = 3'b000;
	localparam logic [2:0] PROT_RD_EXP = 3'b001;
	localparam logic [3:0] WSTRB_EXP = 4'b0011;

	int err_cnt = 0;
	int acc_cnt = 0;
	int bus_cnt = 0;

	// Reference memory, last error-free write per address
	logic [15:0] ref_mem [logic [15:0]];

	logic rst_seen = 1'b0;
	logic start_prev = 1'b0;
	logic busy_prev = 1'b0;

	// Accepted command
	logic exp_wr;
	logic [15:0] exp_addr;
	logic [15:0] exp_wdata;
	// Handshakes seen for it
	int aw_hs;
	int w_hs;
	int ar_hs;

	// VALIDs still waiting at the previous edge
	logic aw_pend = 1'b0;
	logic w_pend = 1'b0;
	logic ar_pend = 1'b0;
	logic [31:0] aw_addr_prev;
	logic [31:0] w_data_prev;
	logic [31:0] ar_addr_prev;
	logic bready_prev = 1'b0;
	logic rready_prev = 1'b0;

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	task automatic check_reset_state();
		if ({busy_i, err_i, awvalid_i, wvalid_i, arvalid_i, bready_i, rready_i} !== 7'b0)
			flag_error("control outputs not low during reset");
		if ({cpu_r_addr_i, cpu_r_data_i} !== 32'h0)
			flag_error("read result outputs not zero during reset");
	endtask

	// Results are valid once busy has fallen
	task automatic close_txn();
		logic [15:0] exp_rdata;
		exp_rdata = ref_mem.exists(exp_addr) ? ref_mem[exp_addr] : 16'h0000;
		if (err_i !== exp_addr[15])
			flag_error($sformatf("err_o %b for address %h", err_i, exp_addr));
		if (exp_wr)
		begin
			if (aw_hs != 1 || w_hs != 1 || ar_hs != 0)
				flag_error($sformatf("write saw AW %0d W %0d AR %0d", aw_hs, w_hs, ar_hs));
			if (!exp_addr[15])
				ref_mem[exp_addr] = exp_wdata;
		end
		else
		begin
			if (ar_hs != 1 || aw_hs != 0 || w_hs != 0)
				flag_error($sformatf("read saw AR %0d AW %0d W %0d", ar_hs, aw_hs, w_hs));
			if (cpu_r_addr_i !== exp_addr)
				flag_error($sformatf("read address %h, expected %h", cpu_r_addr_i, exp_addr));
			if (cpu_r_data_i !== exp_rdata)
				flag_error($sformatf("read data %h at %h, expected %h",
					cpu_r_data_i, exp_addr, exp_rdata));
		end
	endtask

	always @(posedge M_AXI_ACLK)
	begin
		if (!M_AXI_ARESETN)
		begin
			// First edge only loads the reset values
			if (rst_seen)
				check_reset_state();
			rst_seen = 1'b1;
			start_prev = 1'b0;
			busy_prev = 1'b0;
			aw_pend = 1'b0;
			w_pend = 1'b0;
			ar_pend = 1'b0;
			bready_prev = 1'b0;
			rready_prev = 1'b0;
		end
		else
		begin
			// --------------------
			// Completion and acceptance
			// --------------------
			if (busy_prev && !busy_i)
				close_txn();
			// Start edge counts only while idle
			if (start_i && !start_prev && !busy_i)
			begin
				acc_cnt++;
				exp_wr = rw_i;
				exp_addr = cpu_addr_i;
				exp_wdata = cpu_wdata_i;
				aw_hs = 0;
				w_hs = 0;
				ar_hs = 0;
			end

			// --------------------
			// Handshakes
			// --------------------
			if (awvalid_i && awready_i)
			begin
				aw_hs++;
				bus_cnt++;
				if (!busy_i)
					flag_error("AW handshake while idle");
				if (awaddr_i !== {16'h0000, exp_addr} || awprot_i !== PROT_WR_EXP)
					flag_error($sformatf("AW addr %h prot %b", awaddr_i, awprot_i));
			end
			if (wvalid_i && wready_i)
			begin
				w_hs++;
				if (wdata_i !== {16'h0000, exp_wdata} || wstrb_i !== WSTRB_EXP)
					flag_error($sformatf("W data %h strb %b", wdata_i, wstrb_i));
			end
			if (arvalid_i && arready_i)
			begin
				ar_hs++;
				bus_cnt++;
				if (!busy_i)
					flag_error("AR handshake while idle");
				if (araddr_i !== {16'h0000, exp_addr} || arprot_i !== PROT_RD_EXP)
					flag_error($sformatf("AR addr %h prot %b", araddr_i, arprot_i));
			end

			// VALID and payload hold until READY
			if (aw_pend && (awvalid_i !== 1'b1 || awaddr_i !== aw_addr_prev))
				flag_error("AWVALID or AWADDR changed before AWREADY");
			if (w_pend && (wvalid_i !== 1'b1 || wdata_i !== w_data_prev))
				flag_error("WVALID or WDATA changed before WREADY");
			if (ar_pend && (arvalid_i !== 1'b1 || araddr_i !== ar_addr_prev))
				flag_error("ARVALID or ARADDR changed before ARREADY");
			// Response READYs are single-cycle pulses
			if (bready_prev && bready_i)
				flag_error("BREADY high for two cycles");
			if (rready_prev && rready_i)
				flag_error("RREADY high for two cycles");

			start_prev = start_i;
			busy_prev = busy_i;
			aw_pend = awvalid_i && !awready_i;
			w_pend = wvalid_i && !wready_i;
			ar_pend = arvalid_i && !arready_i;
			aw_addr_prev = awaddr_i;
			w_data_prev = wdata_i;
			ar_addr_prev = araddr_i;
			bready_prev = bready_i;
			rready_prev = rready_i;
		end
	end

	assign err_cnt_o = err_cnt;
	assign acc_cnt_o = acc_cnt;
	assign bus_cnt_o = bus_cnt;

endmodule

`default_nettype wire

// File: dv/tb_axil_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axil_master;

	localparam int NUM_TXN = 400;
	localparam int RST_CYCLES = 4;
	// Cycle budget per transaction, worst case plus margin
	localparam int TXN_CYCLES = 40;
	localparam logic [31:0] SEED = 32'h19b7d31c;

	wire M_AXI_ACLK;
	wire M_AXI_ARESETN;

	// CPU side
	logic start;
	logic rw;
	logic [15:0] addr;
	logic [15:0] wdata;
	wire busy;
	wire err;
	wire [15:0] r_addr;
	wire [15:0] r_data;

	// AXI side
	wire [31:0] awaddr;
	wire [2:0] awprot;
	wire awvalid;
	wire awready;
	wire [31:0] axi_wdata;
	wire [3:0] wstrb;
	wire wvalid;
	wire wready;
	wire [1:0] bresp;
	wire bvalid;
	wire bready;
	wire [31:0] araddr;
	wire [2:0] arprot;
	wire arvalid;
	wire arready;
	wire [31:0] rdata;
	wire [1:0] rresp;
	wire rvalid;
	wire rready;

	int err_cnt;
	int acc_cnt;
	int bus_cnt;

	clk_rst_gen #(
		.PERIOD_NS (8),
		.RST_CYCLES (RST_CYCLES)
	) u_clk (
		.clk_o (M_AXI_ACLK),
		.rst_n_o (M_AXI_ARESETN)
	);

	axil_master_top UUT (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.start_i (start),
		.rw_i (rw),
		.cpu_rw_addr_i (addr),
		.cpu_w_data_i (wdata),
		.busy_o (busy),
		.cpu_r_addr_o (r_addr),
		.cpu_r_data_o (r_data),
		.err_o (err),
		.M_AXI_AWADDR (awaddr),
		.M_AXI_AWPROT (awprot),
		.M_AXI_AWVALID (awvalid),
		.M_AXI_AWREADY (awready),
		.M_AXI_WDATA (axi_wdata),
		.M_AXI_WSTRB (wstrb),
		.M_AXI_WVALID (wvalid),
		.M_AXI_WREADY (wready),
		.M_AXI_BRESP (bresp),
		.M_AXI_BVALID (bvalid),
		.M_AXI_BREADY (bready),
		.M_AXI_ARADDR (araddr),
		.M_AXI_ARPROT (arprot),
		.M_AXI_ARVALID (arvalid),
		.M_AXI_ARREADY (arready),
		.M_AXI_RDATA (rdata),
		.M_AXI_RRESP (rresp),
		.M_AXI_RVALID (rvalid),
		.M_AXI_RREADY (rready)
	);

	axil_slave_model u_slave (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.awaddr_i (awaddr),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i (axi_wdata),
		.wstrb_i (wstrb),
		.wvalid_i (wvalid),
		.wready_o (wready),
		.bresp_o (bresp),
		.bvalid_o (bvalid),
		.bready_i (bready),
		.araddr_i (araddr),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o (rdata),
		.rresp_o (rresp),
		.rvalid_o (rvalid),
		.rready_i (rready)
	);

	axil_checker u_chk (
		.M_AXI_ACLK (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.start_i (start),
		.rw_i (rw),
		.cpu_addr_i (addr),
		.cpu_wdata_i (wdata),
		.busy_i (busy),
		.cpu_r_addr_i (r_addr),
		.cpu_r_data_i (r_data),
		.err_i (err),
		.awaddr_i (awaddr),
		.awprot_i (awprot),
		.awvalid_i (awvalid),
		.awready_i (awready),
		.wdata_i (axi_wdata),
		.wstrb_i (wstrb),
		.wvalid_i (wvalid),
		.wready_i (wready),
		.bready_i (bready),
		.araddr_i (araddr),
		.arprot_i (arprot),
		.arvalid_i (arvalid),
		.arready_i (arready),
		.rready_i (rready),
		.err_cnt_o (err_cnt),
		.acc_cnt_o (acc_cnt),
		.bus_cnt_o (bus_cnt)
	);

	// --------------------
	// Stimulus
	// --------------------

	// One request from a falling edge, then wait for busy to drop
	task automatic run_txn(input bit extra_pulse);
		int hold;
		logic [15:0] a;
		hold = 1 + int'($urandom % 3);
		// Eight word addresses so reads often hit earlier writes
		a = 16'h0040 + 16'($urandom % 8) * 16'h0004;
		// About one in five goes to the error region
		if ($urandom % 5 == 0)
			a[15] = 1'b1;
		rw = 1'($urandom);
		addr = a;
		wdata = 16'($urandom);
		start = 1'b1;
		repeat (hold) @(negedge M_AXI_ACLK);
		start = 1'b0;
		if (extra_pulse)
		begin
			@(negedge M_AXI_ACLK);
			if (busy)
			begin
				// Different address, must be ignored
				addr = addr ^ 16'h0004;
				start = 1'b1;
				@(negedge M_AXI_ACLK);
				start = 1'b0;
			end
		end
		while (busy)
			@(negedge M_AXI_ACLK);
	endtask

	initial
	begin
		void'($urandom(SEED));
		start = 1'b0;
		rw = 1'b0;
		addr = 16'h0000;
		wdata = 16'h0000;
		@(posedge M_AXI_ARESETN);
		@(negedge M_AXI_ACLK);
		for (int i = 0; i < NUM_TXN; i++)
		begin
			run_txn(i % 4 == 3);
		end
		repeat (4) @(negedge M_AXI_ACLK);
		if (acc_cnt != NUM_TXN || bus_cnt != NUM_TXN)
			$display("Transaction count mismatch: every idle start edge should give one bus transaction");
		$display("Summary: %0d of %0d requests accepted, %0d bus transactions, %0d errors",
			acc_cnt, NUM_TXN, bus_cnt, err_cnt);
		if (err_cnt == 0 && acc_cnt == NUM_TXN && bus_cnt == NUM_TXN)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (RST_CYCLES + NUM_TXN * TXN_CYCLES) @(posedge M_AXI_ACLK);
		$display("Timeout: the transactions did not finish in the expected number of cycles");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
src/axil_pkg.sv
src/txn_sequencer.sv
src/axil_write_channel.sv
src/axil_read_channel.sv
src/axil_master_top.sv
dv/clk_rst_gen.sv
dv/axil_slave_model.sv
dv/axil_checker.sv
dv/tb_axil_master.sv

// File: Makefile
# Verilator build and run of the AXI4-Lite master testbench

SIM := obj_dir/Vtb_axil_master
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): verilog.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps \
		--top-module tb_axil_master -f verilog.f

# The log decides pass or fail
sim.log: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
